//--- arcade_cfg_pkg.sv
// Arcade board configuration constants
// Game-select byte values, hardware-select codes for the video/input
// hardware variants, host download indices and joystick bit positions.

package arcade_cfg_pkg;

	// ======================================================================
	// Game-select byte, as written by the host on download index 1
	// ======================================================================
	localparam logic [7:0] game_scramble = 8'd0;
	localparam logic [7:0] game_frogger  = 8'd2;
	localparam logic [7:0] game_scobra   = 8'd3;
	localparam logic [7:0] game_tazman   = 8'd4;
	localparam logic [7:0] game_calipso  = 8'd8;
	localparam logic [7:0] game_anteater = 8'd10;
	localparam logic [7:0] game_losttomb = 8'd11;
	localparam logic [7:0] game_stratgyx = 8'd14;
	localparam logic [7:0] game_turtles  = 8'd15;

	// Hardware-select codes seen by the game core
	localparam logic [7:0] hw_scramble = 8'd0;
	localparam logic [7:0] hw_frogger  = 8'd1;
	localparam logic [7:0] hw_scobra   = 8'd2;
	localparam logic [7:0] hw_calipso  = 8'd3;
	localparam logic [7:0] hw_stratgyx = 8'd5;
	localparam logic [7:0] hw_anteater = 8'd6;
	localparam logic [7:0] hw_losttomb = 8'd7;
	localparam logic [7:0] hw_turtles  = 8'd11;

	// ======================================================================
	// Download bus
	// ======================================================================
	localparam logic [7:0] dl_index_game = 8'd1;
	localparam logic [7:0] dl_index_dip  = 8'd254;
	localparam int dl_addr_width = 25;
	localparam int dl_data_width = 8;
	localparam int dip_count     = 8;

	// Joystick word and bit positions
	localparam int joy_width   = 32;
	localparam int joy_right   = 0;
	localparam int joy_left    = 1;
	localparam int joy_down    = 2;
	localparam int joy_up      = 3;
	localparam int joy_fire_a  = 4;
	localparam int joy_fire_b  = 5;
	localparam int joy_fire_c  = 6;
	localparam int joy_fire_d  = 7;
	// fire_e and start1 share a bit on the host side
	localparam int joy_fire_e  = 8;
	localparam int joy_start1  = 8;
	localparam int joy_start2  = 9;
	localparam int joy_coin    = 10;
	localparam int joy_pause   = 11;

endpackage

//--- arcade_video_pkg.sv
// Arcade video constants
// Pixel layout and the pause screen-dim delay.

package arcade_video_pkg;

	// Bits per colour channel
	localparam int color_width = 8;

	// Pixel word is red, green, blue with red in the top byte
	localparam int pixel_width = 24;

	// Width of the paused-cycle counter
	localparam int dim_count_width = 32;

	// Paused cycles before the screen is dimmed
	localparam logic [dim_count_width-1:0] dim_delay_default = 32'd240_000_000;

endpackage

//--- cfg_loader.sv
// Download capture
// Picks the game-select byte and the DIP-switch bytes out of the host
// download stream. Only DIP bytes 0 to 2 are used downstream.

module cfg_loader
(
	input  logic       clk_sys,
	input  logic       arst_n,
	dl_if.sink         dl,
	output logic [7:0] game_sel,
	output logic [7:0] dip_a,
	output logic [7:0] dip_b,
	output logic [7:0] dip_c
);
	import arcade_cfg_pkg::*;

	localparam int dip_sel_width = $clog2(dip_count);

	logic [dl_data_width-1:0] dip_q [dip_count];
	logic                     game_wr;
	logic                     dip_wr;
	logic [dip_sel_width-1:0] dip_sel;

	// Write decode
	assign game_wr = dl.wr && (dl.index == dl_index_game);
	assign dip_wr  = dl.wr && (dl.index == dl_index_dip) && (dl.addr < dip_count);
	assign dip_sel = dl.addr[dip_sel_width-1:0];

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			game_sel <= game_scramble;
			// DIPs open until the host sends its settings
			for (int i = 0; i < dip_count; i++)
				dip_q[i] <= '1;
		end
		else
		begin
			if (game_wr)
				game_sel <= dl.data;
			if (dip_wr)
				dip_q[dip_sel] <= dl.data;
		end
	end

	assign dip_a = dip_q[0];
	assign dip_b = dip_q[1];
	assign dip_c = dip_q[2];

endmodule

//--- dl_if.sv
// Host download bus
// One byte write per cycle with wr high, no back-pressure.

interface dl_if;
	import arcade_cfg_pkg::*;

	logic                     wr;
	logic [7:0]               index;
	logic [dl_addr_width-1:0] addr;
	logic [dl_data_width-1:0] data;

	// Host side
	modport source
	(
		output wr, index, addr, data
	);

	// Capture side
	modport sink
	(
		input wr, index, addr, data
	);

endinterface

//--- input_mapper.sv
// Input port encoder
// Merges both players, builds the four active-low input port bytes and
// the hardware-select code for the selected game, masks ports a to c
// with the DIP bytes and registers the result.

module input_mapper
(
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  logic [arcade_cfg_pkg::joy_width-1:0] joy1,
	input  logic [arcade_cfg_pkg::joy_width-1:0] joy2,
	input  logic                                fire_mode,
	input  logic [7:0]                          game_sel,
	input  logic [7:0]                          dip_a,
	input  logic [7:0]                          dip_b,
	input  logic [7:0]                          dip_c,
	output logic [7:0]                          port_a,
	output logic [7:0]                          port_b,
	output logic [7:0]                          port_c,
	output logic [7:0]                          port_d,
	output logic [7:0]                          hwsel,
	output logic                                pause_button
);
	import arcade_cfg_pkg::*;

	logic [joy_width-1:0] joy;
	logic m_up, m_down, m_left, m_right;
	logic m_fire_a, m_fire_b, m_fire_c, m_fire_d, m_fire_e;
	logic m_start1, m_start2, m_coin;

	logic [7:0] enc_a;
	logic [7:0] enc_b;
	logic [7:0] enc_c;
	logic [7:0] enc_hw;

	// ======================================================================
	// Player merge
	// ======================================================================
	assign joy = joy1 | joy2;

	assign m_right  = joy[joy_right];
	assign m_left   = joy[joy_left];
	assign m_down   = joy[joy_down];
	assign m_up     = joy[joy_up];
	assign m_fire_a = joy[joy_fire_a];
	assign m_fire_b = joy[joy_fire_b];
	assign m_fire_c = joy[joy_fire_c];
	assign m_fire_d = joy[joy_fire_d];
	assign m_fire_e = joy[joy_fire_e];
	assign m_start1 = joy[joy_start1];
	assign m_start2 = joy[joy_start2];
	assign m_coin   = joy[joy_coin];

	// Raw button, edge detection lives in the pause block
	assign pause_button = joy[joy_pause];

	// ======================================================================
	// Per-game layout
	// ======================================================================
	always_comb
	begin
		// Default layout, shared by most of the hardware variants
		enc_hw = hw_scramble;
		enc_a  = ~{m_coin, 1'b0, m_left, m_right, m_fire_a, 1'b0, m_fire_b, m_up};
		enc_b  = ~{m_start1, m_start2, m_left, m_right, m_fire_a, m_fire_b, 2'b00};
		enc_c  = ~{1'b0, m_down, 1'b0, m_up, 3'b000, m_down};

		case (game_sel)
			game_scramble:
				enc_hw = hw_scramble;
			game_frogger:
				enc_hw = hw_frogger;
			game_scobra:
				enc_hw = hw_scobra;
			game_turtles:
				enc_hw = hw_turtles;
			game_tazman:
			begin
				// Runs on scobra hardware
				enc_hw = hw_scobra;
				enc_a  = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, m_fire_a, m_fire_b};
				enc_b  = 8'hFF;
				enc_c  = ~{1'b0, m_start2, 5'b00000, m_start1};
			end
			game_calipso:
			begin
				enc_hw = hw_calipso;
				enc_a  = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0,
					m_start2 | m_fire_a};
				enc_b  = ~{2'b00, m_left, m_right, m_down, m_up, 2'b00};
				enc_c  = ~{7'b0000000, m_fire_a | m_start1};
			end
			game_anteater:
			begin
				enc_hw = hw_anteater;
				enc_a  = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, 1'b0, m_fire_a};
				enc_b  = ~{1'b0, m_fire_a, m_left, m_right, m_up, m_down, 2'b00};
				enc_c  = ~{1'b0, m_start2, 5'b00000, m_start1};
			end
			game_losttomb:
			begin
				enc_hw = hw_losttomb;
				enc_a  = ~{m_coin, 1'b0, m_left, m_right, m_down, m_up, m_start1, m_start2};
				// Second stick either moves or fires in four directions
				if (fire_mode)
					enc_b = ~{1'b0, m_fire_e | m_fire_a, m_left, m_right, m_down, m_up,
						2'b00};
				else
					enc_b = ~{1'b0, m_fire_e, m_fire_d, m_fire_a, m_fire_b, m_fire_c,
						2'b00};
				enc_c  = 8'hFF;
			end
			game_stratgyx:
			begin
				enc_hw = hw_stratgyx;
				enc_c  = ~{m_fire_c, m_down, m_fire_c, m_up, 3'b000, m_down};
			end
			default:
				enc_hw = hw_scramble;
		endcase
	end

	// ======================================================================
	// Output register with DIP masking
	// ======================================================================
	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			port_a <= 8'hFF;
			port_b <= 8'hFF;
			port_c <= 8'hFF;
			port_d <= 8'hFF;
			hwsel  <= hw_scramble;
		end
		else
		begin
			port_a <= enc_a & dip_a;
			port_b <= enc_b & dip_b;
			port_c <= enc_c & dip_c;
			// Port d has no DIP bank
			port_d <= 8'hFF;
			hwsel  <= enc_hw;
		end
	end

endmodule

//--- pause_dimmer.sv
// Pause and screen dim
// A pause button press toggles the pause state. After dim_delay paused
// cycles every colour channel of the outgoing pixel is halved.

module pause_dimmer
#(
	parameter logic [arcade_video_pkg::dim_count_width-1:0] dim_delay =
		arcade_video_pkg::dim_delay_default
)
(
	input  logic                                    clk_sys,
	input  logic                                    arst_n,
	input  logic                                    pause_button,
	input  logic [arcade_video_pkg::pixel_width-1:0] pixel_in,
	output logic                                    paused,
	output logic [arcade_video_pkg::pixel_width-1:0] pixel_out
);
	import arcade_video_pkg::*;

	localparam int channels = pixel_width / color_width;

	logic                       button_q;
	logic [dim_count_width-1:0] dim_count;
	logic [pixel_width-1:0]     pixel_half;

	// Half intensity, each channel on its own
	always_comb
	begin
		for (int i = 0; i < channels; i++)
			pixel_half[i*color_width +: color_width] =
				pixel_in[i*color_width +: color_width] >> 1;
	end

	always_ff @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
		begin
			button_q  <= 1'b0;
			paused    <= 1'b0;
			dim_count <= '0;
			pixel_out <= '0;
		end
		else
		begin
			button_q <= pause_button;
			if (pause_button && !button_q)
				paused <= ~paused;

			pixel_out <= pixel_in;
			if (paused)
			begin
				// Count up and hold once the delay is reached
				if (dim_count < dim_delay)
					dim_count <= dim_count + 1'b1;
				else
					pixel_out <= pixel_half;
			end
			else
				dim_count <= '0;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the scramble_ctrl simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_scramble_ctrl \
	-f scramble_ctrl.f \
	-o sim_scramble_ctrl

./obj_dir/sim_scramble_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- scramble_ctrl.f
arcade_cfg_pkg.sv
arcade_video_pkg.sv
dl_if.sv
cfg_loader.sv
input_mapper.sv
pause_dimmer.sv
scramble_ctrl_top.sv
scramble_ctrl_assertions.sv
tb_scramble_ctrl.sv

//--- scramble_ctrl_assertions.sv
// Scramble control checker
// Concurrent assertions on the top-level ports, bound into the DUT.

module scramble_ctrl_assertions
#(
	parameter int dim_delay = 20
)
(
	input logic        clk_sys,
	input logic        arst_n,
	input logic        dl_wr,
	input logic [31:0] joy1,
	input logic [31:0] joy2,
	input logic        fire_mode,
	input logic [23:0] pixel_in,
	input logic [7:0]  port_a,
	input logic [7:0]  port_b,
	input logic [7:0]  port_c,
	input logic [7:0]  port_d,
	input logic [7:0]  hwsel,
	input logic        paused,
	input logic [23:0] pixel_out
);
	timeunit 1ns;
	timeprecision 1ps;

	logic        pause_btn;
	logic [31:0] run_len;
	int          fail_count = 0;

	assign pause_btn = joy1[11] | joy2[11];

	// Consecutive paused cycles seen so far, saturating
	always @(posedge clk_sys or negedge arst_n)
	begin
		if (!arst_n)
			run_len <= 0;
		else if (!paused)
			run_len <= 0;
		else if (run_len < dim_delay)
			run_len <= run_len + 1;
	end

	function automatic logic [23:0] half(input logic [23:0] p);
		return {1'b0, p[23:17], 1'b0, p[15:9], 1'b0, p[7:1]};
	endfunction

	// ======================================================================
	// Reset state
	// ======================================================================
	a_reset: assert property (@(posedge clk_sys) $rose(arst_n) |->
		(port_a == 8'hFF && port_b == 8'hFF && port_c == 8'hFF && port_d == 8'hFF
		&& hwsel == 8'h00 && !paused && pixel_out == 24'h0))
		else
		begin
			$error("outputs not idle after reset");
			fail_count++;
		end

	// Ports hold when nothing that feeds them has moved
	a_ports: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!dl_wr && !$past(dl_wr) && $stable(joy1) && $stable(joy2) && $stable(fire_mode))
		|=> $stable({port_a, port_b, port_c, port_d, hwsel}))
		else
		begin
			$error("ports changed without an input change");
			fail_count++;
		end

	// Pixel path
	a_pix_full: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!paused || run_len < dim_delay) |=> pixel_out == $past(pixel_in))
		else
		begin
			$error("pixel_out is not the delayed pixel_in");
			fail_count++;
		end

	a_pix_dim: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(paused && run_len >= dim_delay) |=> pixel_out == half($past(pixel_in)))
		else
		begin
			$error("pixel_out is not dimmed");
			fail_count++;
		end

	// Pause toggle
	a_toggle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(pause_btn && !$past(pause_btn)) |=> paused != $past(paused))
		else
		begin
			$error("paused did not flip on a press");
			fail_count++;
		end

	a_hold: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(pause_btn && !$past(pause_btn)) |=> $stable(paused))
		else
		begin
			$error("paused flipped without a press");
			fail_count++;
		end

endmodule

bind scramble_ctrl_top scramble_ctrl_assertions #(.dim_delay(dim_delay)) chk0 (.*);

//--- scramble_ctrl_top.sv
// Scramble board control and display glue
// Download capture, input port encoding and pause with screen dim
// for the multi-game arcade board.

module scramble_ctrl_top
#(
	parameter logic [arcade_video_pkg::dim_count_width-1:0] dim_delay =
		arcade_video_pkg::dim_delay_default
)
(
	input  logic                                     clk_sys,
	input  logic                                     arst_n,
	// Host download stream
	input  logic                                     dl_wr,
	input  logic [7:0]                               dl_index,
	input  logic [arcade_cfg_pkg::dl_addr_width-1:0] dl_addr,
	input  logic [arcade_cfg_pkg::dl_data_width-1:0] dl_data,
	// Player controls
	input  logic [arcade_cfg_pkg::joy_width-1:0]     joy1,
	input  logic [arcade_cfg_pkg::joy_width-1:0]     joy2,
	input  logic                                     fire_mode,
	// Video
	input  logic [arcade_video_pkg::pixel_width-1:0] pixel_in,
	// Game core inputs
	output logic [7:0]                               port_a,
	output logic [7:0]                               port_b,
	output logic [7:0]                               port_c,
	output logic [7:0]                               port_d,
	output logic [7:0]                               hwsel,
	output logic                                     paused,
	output logic [arcade_video_pkg::pixel_width-1:0] pixel_out
);

	logic [7:0] game_sel;
	logic [7:0] dip_a;
	logic [7:0] dip_b;
	logic [7:0] dip_c;
	logic       pause_button;

	// ======================================================================
	// Download bus
	// ======================================================================
	dl_if dl0 ();

	assign dl0.wr    = dl_wr;
	assign dl0.index = dl_index;
	assign dl0.addr  = dl_addr;
	assign dl0.data  = dl_data;

	cfg_loader cfg_loader0
	(
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.dl       (dl0.sink),
		.game_sel (game_sel),
		.dip_a    (dip_a),
		.dip_b    (dip_b),
		.dip_c    (dip_c)
	);

	// ======================================================================
	// Inputs and display
	// ======================================================================
	input_mapper input_mapper0
	(
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.joy1         (joy1),
		.joy2         (joy2),
		.fire_mode    (fire_mode),
		.game_sel     (game_sel),
		.dip_a        (dip_a),
		.dip_b        (dip_b),
		.dip_c        (dip_c),
		.port_a       (port_a),
		.port_b       (port_b),
		.port_c       (port_c),
		.port_d       (port_d),
		.hwsel        (hwsel),
		.pause_button (pause_button)
	);

	pause_dimmer #(.dim_delay(dim_delay)) pause_dimmer0
	(
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.pause_button (pause_button),
		.pixel_in     (pixel_in),
		.paused       (paused),
		.pixel_out    (pixel_out)
	);

endmodule

//--- tb_scramble_ctrl.sv
// Scramble control testbench
// Drives downloads, joysticks and pixels through the DUT, compares ports,
// pause state and pixels with values worked out from the layout rules.

module tb_scramble_ctrl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int dim_delay = 20;
	localparam int cycle_ns  = 100;

	logic clk_sys = 0, arst_n = 0, dl_wr = 0, fire_mode = 0;
	logic [7:0] dl_index = 0, dl_data = 0;
	logic [24:0] dl_addr = 0;
	logic [31:0] joy1 = 0, joy2 = 0;
	logic [23:0] pixel_in = 0, pixel_out;
	logic [7:0] port_a, port_b, port_c, port_d, hwsel;
	logic paused;

	int errors = 0, test_err = 0, tests_run = 0, tests_failed = 0;
	int asrt_seen = 0;
	logic [7:0] dip_m [3] = '{8'hFF, 8'hFF, 8'hFF};
	logic [7:0] games [9] = '{0, 2, 3, 4, 8, 10, 11, 14, 15};
	logic [7:0] codes [9] = '{0, 1, 2, 2, 3, 6, 7, 5, 11};

	scramble_ctrl_top #(.dim_delay(dim_delay)) dut0 (.*);

	always #(cycle_ns / 2) clk_sys = ~clk_sys;

	// Watchdog, six tests of at most 200 cycles plus reset
	initial
	begin
		#((6 * 200 + 4) * cycle_ns);
		$display("Timeout: the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
			test_err++;
		end
	endtask

	task automatic end_test(input string name);
		int asrt_new;
		asrt_new = dut0.chk0.fail_count - asrt_seen;
		asrt_seen = dut0.chk0.fail_count;
		tests_run++;
		if (test_err == 0 && asrt_new == 0)
			$display("PASS %s", name);
		else
		begin
			$display("FAIL %s with %0d errors", name, test_err + asrt_new);
			tests_failed++;
		end
		test_err = 0;
	endtask

	// Port bytes {a, b, c, d} before DIP masking
	function automatic logic [31:0] encode(input logic [7:0] game, input logic [31:0] j,
		input logic fm);
		logic r, l, d, u, fa, fb, fc, fd, fe, s1, s2, c;
		{c, s2, s1, fd, fc, fb, fa, u, d, l, r} = j[10:0];
		fe = j[8];
		if (game == 4)
			return ~{c, 1'b0, l, r, d, u, fa, fb, 8'h00, 1'b0, s2, 5'b0, s1, 8'h00};
		if (game == 11 && fm)
			return ~{c, 1'b0, l, r, d, u, s1, s2, 1'b0, fe | fa, l, r, d, u, 2'b0, 16'h0};
		if (game == 11)
			return ~{c, 1'b0, l, r, d, u, s1, s2, 1'b0, fe, fd, fa, fb, fc, 2'b0, 16'h0};
		return ~{c, 1'b0, l, r, fa, 1'b0, fb, u, s1, s2, l, r, fa, fb, 2'b0,
			1'b0, d, 1'b0, u, 3'b0, d, 8'h00};
	endfunction

	task automatic check_ports(input logic [7:0] game);
		logic [31:0] e;
		e = encode(game, joy1 | joy2, fire_mode);
		check("port_a", port_a, e[31:24] & dip_m[0]);
		check("port_b", port_b, e[23:16] & dip_m[1]);
		check("port_c", port_c, e[15:8] & dip_m[2]);
		check("port_d", port_d, e[7:0]);
	endtask

	task automatic dl_write(input logic [7:0] idx, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		dl_wr <= 1;
		dl_index <= idx;
		dl_addr <= addr;
		dl_data <= data;
		@(posedge clk_sys);
		dl_wr <= 0;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic apply_joy(input logic [31:0] j1, input logic [31:0] j2, input logic fm);
		@(posedge clk_sys);
		joy1 <= j1;
		joy2 <= j2;
		fire_mode <= fm;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic random_presses(input logic [7:0] game, input int n, input logic fm);
		logic [31:0] j;
		int sel;
		for (int i = 0; i < n; i++)
		begin
			// Bits 0 to 10 only, bit 11 would pause
			j = $urandom & 32'h7FF;
			sel = $urandom % 3;
			apply_joy(sel == 1 ? 32'h0 : j, sel == 0 ? 32'h0 : ($urandom & 32'h7FF), fm);
			check_ports(game);
		end
	endtask

	initial
	begin
		logic [23:0] pix, half_pix;
		void'($urandom(71761));

		repeat (4) @(posedge clk_sys);
		arst_n <= 1;

		// 1. Reset state
		@(negedge clk_sys);
		check("port_a", port_a, 8'hFF);
		check("port_b", port_b, 8'hFF);
		check("port_c", port_c, 8'hFF);
		check("port_d", port_d, 8'hFF);
		check("hwsel", hwsel, 8'h00);
		check("paused", paused, 1'b0);
		@(posedge clk_sys);
		pix = $urandom;
		pixel_in <= pix;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("pixel_out", pixel_out, pix);
		end_test("reset state");

		// 2. Game select
		for (int i = 0; i < 9; i++)
		begin
			dl_write(1, 0, games[i]);
			check("hwsel", hwsel, codes[i]);
		end
		dl_write(5, 0, 8'd4);
		check("hwsel", hwsel, codes[8]);
		dl_write(1, 0, 8'd0);
		end_test("game select");

		// 3. Default layout with DIP masks
		for (int i = 0; i < 3; i++)
		begin
			dip_m[i] = $urandom;
			dl_write(254, i, dip_m[i]);
		end
		random_presses(0, 30, 0);
		end_test("default layout");

		// 4. tazman and losttomb
		dl_write(1, 0, 8'd4);
		random_presses(4, 15, 0);
		dl_write(1, 0, 8'd11);
		random_presses(11, 15, 1);
		random_presses(11, 15, 0);
		end_test("tazman and losttomb");

		// 5. Pause and dim
		dl_write(1, 0, 8'd0);
		apply_joy(0, 0, 0);
		pix = $urandom;
		for (int c = 0; c < 3; c++)
			half_pix[c*8 +: 8] = pix[c*8 +: 8] >> 1;
		@(posedge clk_sys);
		pixel_in <= pix;
		joy1 <= 32'h800;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("paused", paused, 1'b1);
		@(posedge clk_sys);
		joy1 <= 0;
		repeat (dim_delay - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check("pixel_out", pixel_out, pix);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("pixel_out", pixel_out, half_pix);
		@(posedge clk_sys);
		joy2 <= 32'h800;
		@(posedge clk_sys);
		joy2 <= 0;
		@(negedge clk_sys);
		check("paused", paused, 1'b0);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("pixel_out", pixel_out, pix);
		end_test("pause and dim");

		// 6. DIP writes that must not reach a port
		apply_joy($urandom & 32'h7FF, 0, 0);
		for (int a = 3; a < 8; a++)
			dl_write(254, a, 8'h00);
		dl_write(254, 8, 8'h00);
		dl_write(254, 25'h100, 8'h00);
		check_ports(0);
		end_test("DIP addresses");

		$display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, dut0.chk0.fail_count);
		if (errors == 0 && dut0.chk0.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
